// ==== source/gfx_map_pkg.sv ====
// Shared widths, layer and game codes, bank encodings
// and the packed structs passed between the mapper stages
`default_nettype none

package gfx_map_pkg;

    // Field widths
    localparam int GAME_W = 6;
    localparam int CODE_W = 16;
    localparam int ROW_W  = 4;
    localparam int ROM_AW = 20;
    localparam int NIB_W  = 4;

    // Layer fetcher codes
    localparam logic [2:0] LAYER_OBJ   = 3'd0;
    localparam logic [2:0] LAYER_SCR1  = 3'd1;
    localparam logic [2:0] LAYER_SCR2  = 3'd2;
    localparam logic [2:0] LAYER_SCR3  = 3'd3;
    localparam logic [2:0] LAYER_STARS = 3'd4;

    // Built-in game ids, unknown ids fall back to generic
    localparam logic [GAME_W-1:0] GAME_GENERIC = 6'd0;
    localparam logic [GAME_W-1:0] GAME_SPLIT   = 6'd1;
    localparam logic [GAME_W-1:0] GAME_STACKED = 6'd2;

    // One-hot bank codes
    localparam logic [3:0] BANK_NONE = 4'b0000;
    localparam logic [3:0] BANK_0    = 4'b0001;
    localparam logic [3:0] BANK_1    = 4'b0010;
    localparam logic [3:0] BANK_2    = 4'b0100;
    localparam logic [3:0] BANK_3    = 4'b1000;

    // Upper nibble thresholds for the alternate bank set
    localparam logic [NIB_W-1:0] SPLIT_SCR2_HI  = 4'd8;
    localparam logic [NIB_W-1:0] STACKED_OBJ_HI = 4'd4;

    // Request from a layer fetcher
    typedef struct packed {
        logic              valid;
        logic [2:0]        layer;
        logic [CODE_W-1:0] code;
        logic [ROW_W-1:0]  row;
    } gfx_req_t;

    // Bank table output
    typedef struct packed {
        logic              valid;
        logic [CODE_W-1:0] code;
        logic [ROW_W-1:0]  row;
        logic [3:0]        bank;
    } bank_sel_t;

    // Bank mapper output
    typedef struct packed {
        logic              valid;
        logic [CODE_W-1:0] code;
        logic [ROW_W-1:0]  row;
        logic [NIB_W-1:0]  offset;
        logic [NIB_W-1:0]  mask;
        logic              unmapped;
    } region_t;

    // Board configuration words, bank 0 in the lowest nibble
    typedef struct packed {
        logic [4*NIB_W-1:0] bank_offset;
        logic [4*NIB_W-1:0] bank_mask;
    } gfx_cfg_t;

endpackage

`default_nettype wire

// ==== source/gfx_bank_table.sv ====
// Per-game bank table: primary and alternate bank per layer,
// set select from the code range, registered one-hot result
`default_nettype none

module gfx_bank_table (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic [gfx_map_pkg::GAME_W-1:0] game,
    input  wire gfx_map_pkg::gfx_req_t         req,
    output gfx_map_pkg::bank_sel_t             sel
);

    // Upper nibble of the tile code
    logic [gfx_map_pkg::NIB_W-1:0] hi;

    // Primary and alternate bank, plus which one applies
    logic [3:0] bank_a;
    logic [3:0] bank_b;
    logic       set_used;

    // Stage registers
    logic                          sel_valid;
    logic [3:0]                    sel_bank;
    logic [gfx_map_pkg::CODE_W-1:0] sel_code;
    logic [gfx_map_pkg::ROW_W-1:0]  sel_row;

    assign hi = req.code[gfx_map_pkg::CODE_W-1 -: gfx_map_pkg::NIB_W];

    always_comb begin
        // No bank unless a rule below assigns one
        bank_a   = gfx_map_pkg::BANK_NONE;
        bank_b   = gfx_map_pkg::BANK_NONE;
        set_used = 1'b0;
        // Layers 5 to 7 have no fetcher behind them
        if (req.layer <= gfx_map_pkg::LAYER_STARS) begin
            case (game)
                gfx_map_pkg::GAME_SPLIT: begin
                    case (req.layer)
                        gfx_map_pkg::LAYER_OBJ:  bank_a = gfx_map_pkg::BANK_0;
                        gfx_map_pkg::LAYER_SCR1: bank_a = gfx_map_pkg::BANK_1;
                        gfx_map_pkg::LAYER_SCR2: begin
                            // Upper code range moves to bank 2
                            bank_a   = gfx_map_pkg::BANK_1;
                            bank_b   = gfx_map_pkg::BANK_2;
                            set_used = hi >= gfx_map_pkg::SPLIT_SCR2_HI;
                        end
                        gfx_map_pkg::LAYER_SCR3: bank_a = gfx_map_pkg::BANK_2;
                        default:                 bank_a = gfx_map_pkg::BANK_3;
                    endcase
                end
                gfx_map_pkg::GAME_STACKED: begin
                    case (req.layer)
                        gfx_map_pkg::LAYER_OBJ: begin
                            // Objects spill into bank 1 above the first quarter
                            bank_a   = gfx_map_pkg::BANK_0;
                            bank_b   = gfx_map_pkg::BANK_1;
                            set_used = hi >= gfx_map_pkg::STACKED_OBJ_HI;
                        end
                        gfx_map_pkg::LAYER_SCR1,
                        gfx_map_pkg::LAYER_SCR2: bank_a = gfx_map_pkg::BANK_2;
                        gfx_map_pkg::LAYER_SCR3: bank_a = gfx_map_pkg::BANK_3;
                        // Star field has no ROM on this board
                        default:                 bank_a = gfx_map_pkg::BANK_NONE;
                    endcase
                end
                // Generic and unknown games share bank 0
                default: bank_a = gfx_map_pkg::BANK_0;
            endcase
        end
    end

    // Strobe and bank
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel_valid <= 1'b0;
            sel_bank  <= gfx_map_pkg::BANK_NONE;
        end else begin
            sel_valid <= req.valid;
            sel_bank  <= set_used ? bank_b : bank_a;
        end
    end

    // Code and row ride along
    always_ff @(posedge clk) begin
        sel_code <= req.code;
        sel_row  <= req.row;
    end

    assign sel = '{
        valid: sel_valid,
        code:  sel_code,
        row:   sel_row,
        bank:  sel_bank
    };

endmodule

`default_nettype wire

// ==== source/gfx_bank_mapper.sv ====
// Bank to region decode: offset and mask nibbles from the
// configuration words, unmapped flag in the same stage
`default_nettype none

module gfx_bank_mapper (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire gfx_map_pkg::gfx_cfg_t  cfg,
    input  wire gfx_map_pkg::bank_sel_t sel,
    output gfx_map_pkg::region_t        region
);

    // Upper code nibble, tested against the new mask
    logic [gfx_map_pkg::NIB_W-1:0] hi;

    // Decoded nibbles before the register
    logic [gfx_map_pkg::NIB_W-1:0] offset_d;
    logic [gfx_map_pkg::NIB_W-1:0] mask_d;
    logic                          unmapped_d;

    // Stage registers
    logic                           reg_valid;
    logic [gfx_map_pkg::NIB_W-1:0]  reg_offset;
    logic [gfx_map_pkg::NIB_W-1:0]  reg_mask;
    logic                           reg_unmapped;
    logic [gfx_map_pkg::CODE_W-1:0] reg_code;
    logic [gfx_map_pkg::ROW_W-1:0]  reg_row;

    assign hi = sel.code[gfx_map_pkg::CODE_W-1 -: gfx_map_pkg::NIB_W];

    always_comb begin
        case (sel.bank)
            gfx_map_pkg::BANK_0: begin
                offset_d = cfg.bank_offset[3:0];
                mask_d   = cfg.bank_mask[3:0];
            end
            gfx_map_pkg::BANK_1: begin
                offset_d = cfg.bank_offset[7:4];
                mask_d   = cfg.bank_mask[7:4];
            end
            gfx_map_pkg::BANK_2: begin
                offset_d = cfg.bank_offset[11:8];
                mask_d   = cfg.bank_mask[11:8];
            end
            gfx_map_pkg::BANK_3: begin
                offset_d = cfg.bank_offset[15:12];
                mask_d   = cfg.bank_mask[15:12];
            end
            // No bank, pass the code through untouched
            default: begin
                offset_d = '0;
                mask_d   = '1;
            end
        endcase
        // Missing bank or code bits outside the region
        unmapped_d = (sel.bank == gfx_map_pkg::BANK_NONE) || (|(hi & ~mask_d));
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            reg_valid    <= 1'b0;
            reg_offset   <= '0;
            reg_mask     <= '0;
            reg_unmapped <= 1'b1;
        end else begin
            reg_valid    <= sel.valid;
            reg_offset   <= offset_d;
            reg_mask     <= mask_d;
            reg_unmapped <= unmapped_d;
        end
    end

    always_ff @(posedge clk) begin
        reg_code <= sel.code;
        reg_row  <= sel.row;
    end

    assign region = '{
        valid:    reg_valid,
        code:     reg_code,
        row:      reg_row,
        offset:   reg_offset,
        mask:     reg_mask,
        unmapped: reg_unmapped
    };

endmodule

`default_nettype wire

// ==== source/gfx_addr_compose.sv ====
// ROM word address build from region, masked code, tile index
// and row, registered with the strobe and unmapped flag
`default_nettype none

module gfx_addr_compose (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire gfx_map_pkg::region_t         region,
    output logic                              rom_req,
    output logic [gfx_map_pkg::ROM_AW-1:0]    rom_addr,
    output logic                              unmapped
);

    // Region select bits of the tile code
    logic [gfx_map_pkg::NIB_W-1:0] hi;
    // Top nibble of the ROM address
    logic [gfx_map_pkg::NIB_W-1:0] top;
    logic [gfx_map_pkg::ROM_AW-1:0] addr_d;

    assign hi  = region.code[gfx_map_pkg::CODE_W-1 -: gfx_map_pkg::NIB_W];
    assign top = region.offset | (hi & region.mask);

    // Region, then tile index, then row within the tile
    assign addr_d = {
        top,
        region.code[gfx_map_pkg::CODE_W-gfx_map_pkg::NIB_W-1:0],
        region.row
    };

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_req  <= 1'b0;
            rom_addr <= '0;
            unmapped <= 1'b1;
        end else begin
            // Strobe fires for unmapped tiles as well
            rom_req <= region.valid;
            // Hold the last result between requests
            if (region.valid) begin
                rom_addr <= addr_d;
                unmapped <= region.unmapped;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/gfx_mapper_top.sv ====
// Graphics ROM address mapper top, three stage chain:
// bank table, bank mapper, address compose
`default_nettype none

module gfx_mapper_top (
    input  wire logic                          clk,
    input  wire logic                          rst,
    // Configuration levels, stable while requests flow
    input  wire logic [gfx_map_pkg::GAME_W-1:0] game,
    input  wire gfx_map_pkg::gfx_cfg_t         cfg,
    // Fetcher request, valid bit is the strobe
    input  wire gfx_map_pkg::gfx_req_t         req,
    // Result three cycles after the request
    output logic                               rom_req,
    output logic [gfx_map_pkg::ROM_AW-1:0]     rom_addr,
    output logic                               unmapped
);

    // Stage one to stage two
    gfx_map_pkg::bank_sel_t sel;
    // Stage two to stage three
    gfx_map_pkg::region_t   region;

    // Game and code range to one-hot bank
    gfx_bank_table u_bank_table (
        .clk  (clk),
        .rst  (rst),
        .game (game),
        .req  (req),
        .sel  (sel)
    );

    // One-hot bank to offset, mask and unmapped
    gfx_bank_mapper u_bank_mapper (
        .clk    (clk),
        .rst    (rst),
        .cfg    (cfg),
        .sel    (sel),
        .region (region)
    );

    // Final ROM word address
    gfx_addr_compose u_addr_compose (
        .clk      (clk),
        .rst      (rst),
        .region   (region),
        .rom_req  (rom_req),
        .rom_addr (rom_addr),
        .unmapped (unmapped)
    );

endmodule

`default_nettype wire

// ==== test/gfx_mapper_assertions.sv ====
// Bound checks on the mapper top: fixed three cycle latency
// and a zero address before the first ROM request
`default_nettype none

module gfx_mapper_assertions (
    input wire logic                           clk,
    input wire logic                           rst,
    input wire gfx_map_pkg::gfx_req_t          req,
    input wire logic                           rom_req,
    input wire logic [gfx_map_pkg::ROM_AW-1:0] rom_addr
);

    // Set by the first ROM request after reset
    logic seen_req;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            seen_req <= 1'b0;
        end else if (rom_req) begin
            seen_req <= 1'b1;
        end
    end

    // Each strobe leaves exactly three cycles after it entered
    latency_check: assert property (
        @(posedge clk) disable iff (rst) rom_req == $past(req.valid, 3)
    ) else $error("rom_req does not follow the request valid by three cycles");

    // Nothing but zero on the address bus until the first result
    idle_addr_check: assert property (
        @(posedge clk) disable iff (rst) (!seen_req && !rom_req) |-> (rom_addr == '0)
    ) else $error("rom_addr left zero before the first ROM request");

endmodule

bind gfx_mapper_top gfx_mapper_assertions u_assertions (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .rom_req  (rom_req),
    .rom_addr (rom_addr)
);

`default_nettype wire

// ==== test/gfx_mapper_tb.sv ====
// Graphics ROM address mapper testbench with file driven requests,
// random gaps, result queue checks and a watchdog
`default_nettype none

module gfx_mapper_tb;

    // Expected result of one request
    typedef struct packed {
        logic                           unmapped;
        logic [gfx_map_pkg::ROM_AW-1:0] addr;
    } expect_t;

    logic                           clk;
    logic                           rst;
    logic [gfx_map_pkg::GAME_W-1:0] game;
    gfx_map_pkg::gfx_cfg_t          cfg;
    gfx_map_pkg::gfx_req_t          req;
    logic                           rom_req;
    logic [gfx_map_pkg::ROM_AW-1:0] rom_addr;
    logic                           unmapped;

    // Eight words per record and room for 64 records
    logic [31:0] stim_mem [0:511];
    int          num_recs;
    bit          loaded;
    expect_t     exp_q[$];
    logic [31:0] lfsr;
    int          check_errs;
    int          proto_errs;

    gfx_mapper_top dut (
        .clk      (clk),
        .rst      (rst),
        .game     (game),
        .cfg      (cfg),
        .req      (req),
        .rom_req  (rom_req),
        .rom_addr (rom_addr),
        .unmapped (unmapped)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Right shift Galois LFSR with taps x^32 + x^31 + x^29 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = {1'b0, s[31:1]} ^ (s[0] ? 32'hD000_0001 : 32'h0);
    endfunction

    // Idle for 0 to 3 cycles from two random bits
    task automatic idle_gap();
        int gap;
        gap = 0;
        for (int b = 0; b < 2; b++) begin
            gap  = (gap << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
        repeat (gap) begin
            @(posedge clk);
            req.valid <= 1'b0;
        end
    endtask

    // Issue one record and queue its expected result
    task automatic drive_record(input int r);
        gfx_map_pkg::gfx_cfg_t new_cfg;
        expect_t               e;
        int                    base;
        base                = r * 8;
        new_cfg.bank_offset = stim_mem[base+1][15:0];
        new_cfg.bank_mask   = stim_mem[base+2][15:0];
        // Config is read one stage late so drain first
        if (new_cfg != cfg) begin
            @(posedge clk);
            req.valid <= 1'b0;
            while (exp_q.size() != 0) @(negedge clk);
        end
        @(posedge clk);
        game       <= stim_mem[base][gfx_map_pkg::GAME_W-1:0];
        cfg        <= new_cfg;
        req.valid  <= 1'b1;
        req.layer  <= stim_mem[base+3][2:0];
        req.code   <= stim_mem[base+4][15:0];
        req.row    <= stim_mem[base+5][3:0];
        e.unmapped = stim_mem[base+6][0];
        e.addr     = stim_mem[base+7][gfx_map_pkg::ROM_AW-1:0];
        exp_q.push_back(e);
    endtask

    // Result monitor samples settled outputs on the falling edge
    always @(negedge clk) begin
        expect_t e;
        if (!rst && rom_req) begin
            if (exp_q.size() == 0) begin
                $display("ROM request at %0t with no request outstanding", $time);
                proto_errs++;
            end else begin
                e = exp_q.pop_front();
                assert (rom_addr == e.addr) else begin
                    $display("CHECK FAILED at %0t: rom_addr %05h, expected %05h",
                             $time, rom_addr, e.addr);
                    check_errs++;
                end
                assert (unmapped == e.unmapped) else begin
                    $display("CHECK FAILED at %0t: unmapped %0b, expected %0b for addr %05h",
                             $time, unmapped, e.unmapped, e.addr);
                    check_errs++;
                end
            end
        end
    end

    initial begin
        rst        = 1'b1;
        game       = '0;
        cfg        = '0;
        req        = '0;
        lfsr       = 32'h9353_32a7;
        check_errs = 0;
        proto_errs = 0;
        loaded     = 1'b0;
        // Unread words keep ffff in the upper half
        for (int i = 0; i < 512; i++) stim_mem[i] = 32'hffff_0000 | 32'(i);
        $readmemh("test/gfx_mapper_stim.txt", stim_mem);
        num_recs = 0;
        while (num_recs < 64 && stim_mem[num_recs*8][31:16] != 16'hffff) num_recs++;
        loaded = 1'b1;
        if (num_recs == 0) begin
            $display("No stimulus records were read from the data file");
            proto_errs++;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        // Idle outputs before the first request
        repeat (2) begin
            @(negedge clk);
            assert (!rom_req && unmapped && rom_addr == '0) else begin
                $display("CHECK FAILED at %0t: outputs not idle after reset", $time);
                check_errs++;
            end
        end
        for (int r = 0; r < num_recs; r++) begin
            drive_record(r);
            idle_gap();
        end
        @(posedge clk);
        req.valid <= 1'b0;
        // Last result is due three cycles after its request
        repeat (5) @(posedge clk);
        if (exp_q.size() != 0) begin
            $display("%0d expected results never came out of the DUT", exp_q.size());
            proto_errs += exp_q.size();
        end
        $display("Errors: %0d value mismatches, %0d protocol errors", check_errs, proto_errs);
        if (check_errs == 0 && proto_errs == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Watchdog scaled by the record count
    initial begin
        wait (loaded);
        #((num_recs * 8 + 20) * 10);
        $display("Watchdog expired before all requests were checked");
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== gfx_mapper.f ====
source/gfx_map_pkg.sv
source/gfx_bank_table.sv
source/gfx_bank_mapper.sv
source/gfx_addr_compose.sv
source/gfx_mapper_top.sv
test/gfx_mapper_assertions.sv
test/gfx_mapper_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the graphics mapper testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -j 0 \
    --top-module gfx_mapper_tb \
    -f gfx_mapper.f \
    -o gfx_mapper_sim

./obj_dir/gfx_mapper_sim 2>&1 | tee sim.log

if grep -q "Test FAILED" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi
echo "Simulation finished without a reported failure"

// ==== test/gfx_mapper_stim.txt ====
// game bank_offset bank_mask layer code row exp_unmapped exp_addr (all hex)
// Generic game, bank 0 offset 2 with a wide mask
00 c842 1b3f 0 1234 5 0 32345
00 c842 1b3f 1 a5c3 f 0 a5c3f
00 c842 1b3f 2 4001 0 0 60010
00 c842 1b3f 3 ffff 7 0 ffff7
00 c842 1b3f 4 0abc 1 0 2abc1
05 c842 1b3f 2 5123 2 0 71232
3f c842 1b3f 0 8000 e 0 a000e
// Split game, SCR2 bank chosen by the code range
01 c842 1b3f 0 2345 3 0 23453
01 c842 1b3f 1 1010 4 0 50104
01 c842 1b3f 2 7fff 0 1 7fff0
01 c842 1b3f 2 8000 0 0 80000
01 c842 1b3f 2 3210 9 0 72109
01 c842 1b3f 2 9abc 1 0 9abc1
01 c842 1b3f 2 cabc 1 1 8abc1
01 c842 1b3f 3 0123 6 0 81236
01 c842 1b3f 4 1f00 2 0 df002
01 c842 1b3f 4 2f00 2 1 cf002
01 c842 1b3f 6 1234 1 1 12341
// Stacked game, object spill and missing star bank
02 c842 1b3f 0 3456 8 0 34568
02 c842 1b3f 0 4456 8 1 44568
02 c842 1b3f 0 5000 3 1 50003
02 c842 1b3f 1 0777 7 0 87777
02 c842 1b3f 2 b000 a 0 b000a
02 c842 1b3f 3 1111 1 0 d1111
02 c842 1b3f 4 5678 2 1 56782
02 c842 1b3f 7 e001 0 1 e0010
00 c842 1b3f 5 0000 0 1 00000
// Second board setup, all masks empty
00 3210 0000 0 0abc 4 0 0abc4
00 3210 0000 0 7abc 4 1 0abc4
01 3210 0000 1 0555 5 0 15555
01 3210 0000 4 0999 9 0 39999
02 3210 0000 1 f000 1 1 20001
02 3210 0000 4 f000 1 1 f0001
// Back to the first setup, mixed games
02 c842 1b3f 0 0001 1 0 20011
01 c842 1b3f 2 8001 1 0 80011
00 c842 1b3f 4 1001 1 0 30011
01 c842 1b3f 4 3001 1 1 d0011
